/* hw/cellfifo_pkg.sv */
// Cell FIFO shared definitions
package cellfifo_pkg;

    // ************************************************************************
    // sizes and thresholds
    // ************************************************************************
    localparam int ADDR_SIZE = 6;
    localparam int DATA_SIZE = 16;

    // longest legal cell, in words
    localparam int MAX_LEN   = 8;

    // must lie strictly between MAX_LEN and USED_MAX - MAX_LEN
    localparam int AFULL_NUM = 40;

    localparam int RAM_DEPTH = 1 << ADDR_SIZE;

    // ************************************************************************
    // shared types
    // ************************************************************************
    typedef logic [ADDR_SIZE-1:0] addr_t;
    typedef logic [DATA_SIZE-1:0] data_t;

    // word as stored in the RAM and handed to the reader
    typedef struct packed {
        logic  eoc;
        data_t data;
    } cell_word_t;

    // one slot is wasted so that full and empty can be told apart
    localparam addr_t USED_MAX   = addr_t'(RAM_DEPTH - 1);
    localparam addr_t USED_NFULL = addr_t'(RAM_DEPTH - 2);

    // cell length just before the oversize limit
    localparam addr_t CELL_LAST  = addr_t'(MAX_LEN - 1);

    // almost-full level as an occupancy value
    localparam addr_t AFULL_LVL  = addr_t'(AFULL_NUM);

endpackage

/* hw/cellfifo_ram.sv */
// Cell FIFO storage
`timescale 1ns/1ps

module cellfifo_ram
    import cellfifo_pkg::*;
(
    input  logic       clk,
    input  logic       wen,
    input  addr_t      waddr,
    input  cell_word_t wdata,
    input  logic       ren,
    input  addr_t      raddr,
    output cell_word_t rdata
);

    cell_word_t mem [RAM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds its value between reads
    always_ff @(posedge clk)
    begin
        if (ren)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* hw/cellfifo_wr_logic.sv */
// Cell FIFO write side
`timescale 1ns/1ps

module cellfifo_wr_logic
    import cellfifo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_vld,
    input  cell_word_t wr_word,
    input  logic       wr_drop,
    input  addr_t      rd_addr,
    output logic       wr_full,
    output logic       wr_afull,
    output logic       wr_over,
    output logic       fifo_err,
    output addr_t      wr_used,
    output addr_t      soc_addr,
    output logic       ram_wen,
    output addr_t      ram_waddr,
    output cell_word_t ram_wdata
);

    addr_t wr_addr;
    addr_t cell_len;
    logic  over_hld;
    logic  wr_eoc;
    logic  cell_drop;
    logic  cell_commit;
    logic  addr_inc;

    assign wr_eoc = wr_vld & wr_word.eoc;

    // the open cell is thrown away on user request, on an earlier overflow
    // inside the cell, or when the last word itself meets a full FIFO
    assign cell_drop = wr_drop | over_hld | wr_full;

    assign cell_commit = wr_eoc & ~cell_drop & ~fifo_err;

    // write address moves on every accepted word, eoc included
    assign addr_inc = wr_vld & ~wr_full & ~fifo_err & ~(wr_word.eoc & cell_drop);

    assign cell_len = wr_addr - soc_addr;
    assign wr_used  = wr_addr - rd_addr;

    // ************************************************************************
    // write and cell start addresses
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_addr <= '0;
        end
        else if (fifo_err)
        begin
            // oversize cell, back to the cell start right away
            wr_addr <= soc_addr;
        end
        else if (wr_eoc && cell_drop)
        begin
            wr_addr <= soc_addr;
        end
        else if (addr_inc)
        begin
            wr_addr <= wr_addr + addr_t'(1);
        end
    end

    // soc_addr marks the boundary of committed data for the read side
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            soc_addr <= '0;
        end
        else if (cell_commit)
        begin
            soc_addr <= wr_addr + addr_t'(1);
        end
    end

    // ************************************************************************
    // oversize and overflow tracking
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fifo_err <= 1'b0;
        end
        else if (wr_eoc)
        begin
            fifo_err <= 1'b0;
        end
        else if (wr_vld && cell_len == CELL_LAST)
        begin
            // MAX_LEN-th word and still no end of cell
            fifo_err <= 1'b1;
        end
    end

    // held until the end of the open cell
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            over_hld <= 1'b0;
        end
        else if (wr_eoc)
        begin
            over_hld <= 1'b0;
        end
        else if (wr_vld && wr_full)
        begin
            over_hld <= 1'b1;
        end
    end

    // ************************************************************************
    // status flags
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_full  <= 1'b0;
            wr_afull <= 1'b0;
            wr_over  <= 1'b0;
        end
        else
        begin
            wr_full  <= (wr_used == USED_MAX) || (wr_used == USED_NFULL && addr_inc);
            wr_afull <= (wr_used >= AFULL_LVL);
            wr_over  <= wr_vld & wr_full;
        end
    end

    // ************************************************************************
    // RAM write port
    // ************************************************************************
    assign ram_wen   = wr_vld & ~wr_full & ~fifo_err;
    assign ram_waddr = wr_addr;
    assign ram_wdata = wr_word;

endmodule

/* hw/cellfifo_rd_logic.sv */
// Cell FIFO read side
`timescale 1ns/1ps

module cellfifo_rd_logic
    import cellfifo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_en,
    input  addr_t      soc_addr,
    input  cell_word_t ram_rdata,
    output addr_t      rd_addr,
    output logic       ram_ren,
    output addr_t      ram_raddr,
    output logic       rd_vld,
    output cell_word_t rd_word,
    output logic       rd_empty
);

    logic rd_req;

    // ************************************************************************
    // fetch control
    // ************************************************************************

    // only words below the committed boundary may be fetched
    assign rd_empty = (rd_addr == soc_addr);
    assign rd_req   = rd_en & ~rd_empty;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_addr <= '0;
        end
        else if (rd_req)
        begin
            rd_addr <= rd_addr + addr_t'(1);
        end
    end

    assign ram_ren   = rd_req;
    assign ram_raddr = rd_addr;

    // ************************************************************************
    // output alignment
    // ************************************************************************

    // RAM data shows up one cycle after the request
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_vld <= 1'b0;
        end
        else
        begin
            rd_vld <= rd_req;
        end
    end

    assign rd_word = ram_rdata;

endmodule

/* hw/cellfifo_top.sv */
// Cell FIFO top level
`timescale 1ns/1ps

module cellfifo_top
    import cellfifo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_vld,
    input  cell_word_t wr_word,
    input  logic       wr_drop,
    output logic       wr_full,
    output logic       wr_afull,
    output logic       wr_over,
    output logic       fifo_err,
    output addr_t      wr_used,
    input  logic       rd_en,
    output logic       rd_vld,
    output cell_word_t rd_word,
    output logic       rd_empty
);

    logic       ram_wen;
    addr_t      ram_waddr;
    cell_word_t ram_wdata;
    logic       ram_ren;
    addr_t      ram_raddr;
    cell_word_t ram_rdata;
    addr_t      soc_addr;
    addr_t      rd_addr;

    // ************************************************************************
    // write side, read side and storage
    // ************************************************************************
    cellfifo_wr_logic u_wr_logic (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_vld    (wr_vld),
        .wr_word   (wr_word),
        .wr_drop   (wr_drop),
        .rd_addr   (rd_addr),
        .wr_full   (wr_full),
        .wr_afull  (wr_afull),
        .wr_over   (wr_over),
        .fifo_err  (fifo_err),
        .wr_used   (wr_used),
        .soc_addr  (soc_addr),
        .ram_wen   (ram_wen),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata)
    );

    cellfifo_rd_logic u_rd_logic (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .soc_addr  (soc_addr),
        .ram_rdata (ram_rdata),
        .rd_addr   (rd_addr),
        .ram_ren   (ram_ren),
        .ram_raddr (ram_raddr),
        .rd_vld    (rd_vld),
        .rd_word   (rd_word),
        .rd_empty  (rd_empty)
    );

    cellfifo_ram u_ram (
        .clk   (clk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .ren   (ram_ren),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

endmodule

/* verif/cellfifo_assertions.sv */
// Cell FIFO port assertions
`timescale 1ns/1ps

module cellfifo_assertions
    import cellfifo_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  wr_vld,
    input logic  wr_full,
    input logic  wr_afull,
    input logic  wr_over,
    input logic  fifo_err,
    input addr_t wr_used,
    input logic  rd_en,
    input logic  rd_vld,
    input logic  rd_empty
);

    int fail_cnt = 0;

    task automatic count_failure(input string what);
        $error("%s", what);
        fail_cnt++;
    endtask

    // a read word only follows an honoured request
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld |-> $past(rd_en && !rd_empty))
        else count_failure("rd_vld without an honoured request");

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_over |-> $past(wr_vld && wr_full))
        else count_failure("wr_over without a write while full");

    assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (wr_afull == $past(wr_used >= AFULL_LVL)))
        else count_failure("wr_afull does not follow the occupancy");

    // full after 63 words, and never below 62
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_used == USED_MAX) |=> wr_full)
        else count_failure("wr_full missing after occupancy reached 63");

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_full |-> $past(wr_used >= USED_NFULL))
        else count_failure("wr_full set at low occupancy");

    assert property (@(posedge clk)
        $rose(rst_n) |-> (!wr_full && !wr_afull && !wr_over && !fifo_err && !rd_vld && rd_empty))
        else count_failure("flags not at their reset values");

endmodule

bind cellfifo_top cellfifo_assertions assert_i (.*);

/* verif/cellfifo_tb.sv */
// Cell FIFO testbench
`timescale 1ns/1ps

module cellfifo_tb
    import cellfifo_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int N_CELLS      = 30;
    localparam int DRAIN_CYCLES = 2 * RAM_DEPTH;
    // each test ends in a drain, the fill test writes about one RAM depth first
    localparam int TEST_CYCLES  = N_CELLS * (MAX_LEN + 1) + 5 * DRAIN_CYCLES + 2 * RAM_DEPTH;

    logic       clk;
    logic       rst_n;
    logic       wr_vld;
    cell_word_t wr_word;
    logic       wr_drop;
    logic       wr_full;
    logic       wr_afull;
    logic       wr_over;
    logic       fifo_err;
    addr_t      wr_used;
    logic       rd_en;
    logic       rd_vld;
    cell_word_t rd_word;
    logic       rd_empty;

    integer     seed = 32'h6e0032b2;
    cell_word_t exp_q[$];
    cell_word_t open_q[$];
    logic       cell_lost = 1'b0;
    int         err_cnt = 0;
    int         fails_seen = 0;
    int         test_cnt = 0;
    int         over_cnt = 0;
    int         over_exp = 0;

    cellfifo_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        err_cnt++;
    endtask

    task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // ************************************************************************
    // read port and overflow monitor, sampled on the falling edge
    // ************************************************************************
    always @(negedge clk)
    begin
        if (rst_n && wr_over)
            over_cnt++;
        if (rst_n && rd_vld)
        begin
            if (exp_q.size() == 0)
                report_failure("rd_vld high with no committed word left to read");
            else
                expect_val("rd_word", exp_q.pop_front(), rd_word);
        end
    end

    // drive one word, the model decides whether its cell survives
    task automatic put_word(input logic eoc, input logic drop);
        cell_word_t w;
        w.eoc  = eoc;
        w.data = data_t'($random(seed));
        @(negedge clk);
        wr_vld  = 1'b1;
        wr_word = w;
        wr_drop = eoc & drop;
        if (exp_q.size() + open_q.size() >= int'(USED_MAX))
        begin
            // refused at full occupancy, the whole cell is lost
            expect_val("wr_full", 1, wr_full);
            over_exp++;
            cell_lost = 1'b1;
        end
        else if (!cell_lost)
            open_q.push_back(w);
        if (!eoc && open_q.size() == MAX_LEN)
        begin
            cell_lost = 1'b1;
            open_q.delete();
        end
        if (eoc)
        begin
            if (!drop && !cell_lost)
                foreach (open_q[i])
                    exp_q.push_back(open_q[i]);
            open_q.delete();
            cell_lost = 1'b0;
        end
    endtask

    task automatic go_idle(input int cycles);
        @(negedge clk);
        wr_vld  = 1'b0;
        wr_drop = 1'b0;
        repeat (cycles - 1)
            @(negedge clk);
    endtask

    task automatic send_cell(input int len, input logic drop);
        for (int i = 1; i <= len; i++)
            put_word(i == len, drop);
    endtask

    task automatic send_oversize();
        for (int i = 0; i < MAX_LEN; i++)
            put_word(1'b0, 1'b0);
        go_idle(1);
        expect_val("fifo_err", 1, fifo_err);
        // end of the bad cell clears the error
        put_word(1'b1, 1'b0);
        go_idle(2);
        expect_val("fifo_err", 0, fifo_err);
    endtask

    task automatic finish_test(input string name);
        int wait_cnt;
        int fails;
        wait_cnt = 0;
        rd_en = 1'b1;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_CYCLES)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0)
        begin
            report_failure("committed words did not drain from the FIFO");
            exp_q.delete();
        end
        // a stray word after the drain shows up here
        repeat (4)
            @(negedge clk);
        expect_val("wr_over pulses", over_exp, over_cnt);
        fails = err_cnt + dut_i.assert_i.fail_cnt;
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (fails == fails_seen) ? "ok" : "errors");
        fails_seen = fails;
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************
    initial
    begin
        rst_n   = 1'b0;
        wr_vld  = 1'b0;
        wr_word = '0;
        wr_drop = 1'b0;
        rd_en   = 1'b0;
        repeat (4)
            @(negedge clk);
        rst_n = 1'b1;
        rd_en = 1'b1;
        for (int n = 0; n < N_CELLS; n++)
            send_cell(1 + int'($unsigned($random(seed)) % MAX_LEN), 1'b0);
        go_idle(1);
        finish_test("random cells");
        send_cell(3, 1'b0);
        send_cell(4, 1'b1);
        send_cell(5, 1'b0);
        go_idle(1);
        finish_test("dropped cell");
        send_cell(2, 1'b0);
        send_oversize();
        send_cell(6, 1'b0);
        go_idle(1);
        finish_test("oversize cell");
        // reads stopped, twelve cells fit and the thirteenth overflows
        rd_en = 1'b0;
        repeat (13)
            send_cell(5, 1'b0);
        go_idle(3);
        // only the committed cells are left once the open one is dropped
        expect_val("wr_used", exp_q.size(), wr_used);
        finish_test("fill and overflow");
        for (int i = 0; i < 4; i++)
            put_word(1'b0, 1'b0);
        go_idle(1);
        repeat (4)
        begin
            @(negedge clk);
            expect_val("rd_empty", 1, rd_empty);
            expect_val("rd_vld", 0, rd_vld);
        end
        put_word(1'b1, 1'b0);
        go_idle(1);
        finish_test("partial cell");
        fails_seen = err_cnt + dut_i.assert_i.fail_cnt;
        $display("%0d tests run, %0d checks failed", test_cnt, fails_seen);
        if (fails_seen == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * CLK_PERIOD + 100);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* verilog.f */
hw/cellfifo_pkg.sv
hw/cellfifo_ram.sv
hw/cellfifo_wr_logic.sv
hw/cellfifo_rd_logic.sv
hw/cellfifo_top.sv
verif/cellfifo_assertions.sv
verif/cellfifo_tb.sv
